//--- common/mempool_pkg.sv
// ----------------------------------------------------------
// MemPool sub-group definitions
// Sizes, address fields and TCDM operation encoding
// ----------------------------------------------------------

package mempool_pkg;

  // Sub-group geometry
  localparam int unsigned num_tiles          = 4;
  localparam int unsigned num_banks_per_tile = 2;
  localparam int unsigned bank_depth         = 64;
  localparam int unsigned data_width         = 32;
  localparam int unsigned strb_width         = data_width / 8;

  localparam int unsigned tile_id_width   = $clog2(num_tiles);
  localparam int unsigned bank_id_width   = $clog2(num_banks_per_tile);
  localparam int unsigned row_width       = $clog2(bank_depth);
  localparam int unsigned tile_addr_width = row_width + bank_id_width;
  localparam int unsigned tcdm_addr_width = row_width + tile_id_width + bank_id_width;

  typedef logic [data_width-1:0]      data_t;
  typedef logic [strb_width-1:0]      strb_t;
  typedef logic [tile_id_width-1:0]   tile_id_t;
  typedef logic [bank_id_width-1:0]   bank_id_t;
  typedef logic [row_width-1:0]       row_t;
  typedef logic [tcdm_addr_width-1:0] tcdm_addr_t;
  typedef logic [tile_addr_width-1:0] tile_addr_t;

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } tcdm_op_e;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------

  // Word address layout is {row, tile, bank}
  function automatic tile_id_t addr_tile(tcdm_addr_t addr);
    return addr[bank_id_width +: tile_id_width];
  endfunction

  // Drop the tile field and keep {row, bank}
  function automatic tile_addr_t addr_in_tile(tcdm_addr_t addr);
    return {addr[tcdm_addr_width-1 -: row_width], addr[bank_id_width-1:0]};
  endfunction

endpackage : mempool_pkg

//--- tile/tcdm_bank.sv
// ----------------------------------------------------------
// TCDM bank
// Single-port word SRAM with byte enables and registered read
// ----------------------------------------------------------

module tcdm_bank (
  input  logic               clk_i,
  input  logic               req_i,
  input  logic               we_i,
  input  mempool_pkg::row_t  addr_i,
  input  mempool_pkg::data_t wdata_i,
  input  mempool_pkg::strb_t be_i,
  output mempool_pkg::data_t rdata_o
);

  import mempool_pkg::*;

  data_t mem_q [bank_depth];

  // Read register only loads on a read so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < strb_width; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_o <= mem_q[addr_i];
      end
    end
  end

endmodule : tcdm_bank

//--- tile/mempool_tile.sv
// ----------------------------------------------------------
// MemPool tile
// Two TCDM banks behind a one-entry response slot
// ----------------------------------------------------------

module mempool_tile (
  input  logic                    clk_i,
  input  logic                    rst_i,
  // Request from the local interconnect
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  input  mempool_pkg::tile_id_t   req_ini_i,
  input  mempool_pkg::tile_addr_t req_addr_i,
  input  mempool_pkg::tcdm_op_e   req_op_i,
  input  mempool_pkg::data_t      req_wdata_i,
  input  mempool_pkg::strb_t      req_be_i,
  // Response towards the initiator
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i,
  output mempool_pkg::tile_id_t   resp_ini_o,
  output mempool_pkg::data_t      resp_rdata_o,
  output logic                    resp_write_o
);

  import mempool_pkg::*;

  logic     accept;
  bank_id_t req_bank;
  row_t     req_row;
  data_t    bank_rdata [num_banks_per_tile];

  logic     resp_valid_q;
  tile_id_t ini_q;
  tcdm_op_e op_q;
  bank_id_t bank_q;

  // Slot empty or draining this cycle
  assign req_ready_o = !resp_valid_q || resp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  assign req_bank = req_addr_i[bank_id_width-1:0];
  assign req_row  = req_addr_i[tile_addr_width-1:bank_id_width];

  // ----------------------------------------------------------
  // Banks
  // ----------------------------------------------------------

  for (genvar b = 0; b < num_banks_per_tile; b++) begin : gen_banks
    tcdm_bank i_bank (
      .clk_i  (clk_i                                   ),
      .req_i  (accept && (req_bank == bank_id_t'(b))   ),
      .we_i   (req_op_i == op_write                    ),
      .addr_i (req_row                                 ),
      .wdata_i(req_wdata_i                             ),
      .be_i   (req_be_i                                ),
      .rdata_o(bank_rdata[b]                           )
    );
  end : gen_banks

  // ----------------------------------------------------------
  // Response slot
  // ----------------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      resp_valid_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      ini_q  <= req_ini_i;
      op_q   <= req_op_i;
      bank_q <= req_bank;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_ini_o   = ini_q;
  assign resp_rdata_o = bank_rdata[bank_q];
  assign resp_write_o = (op_q == op_write);

  // Stalled response blocks new work and keeps its payload
  a_resp_hold : assert property (@(posedge clk_i) disable iff (rst_i)
    resp_valid_o && !resp_ready_i |-> !accept ##1
      (resp_valid_o && $stable(resp_ini_o) && $stable(resp_rdata_o)));

endmodule : mempool_tile

//--- interco/rr_arbiter.sv
// ----------------------------------------------------------
// Round-robin arbiter
// One grant per cycle among the masters aiming at a tile
// ----------------------------------------------------------

module rr_arbiter (
  input  logic                             clk_i,
  input  logic                             rst_i,
  input  logic [mempool_pkg::num_tiles-1:0] req_i,
  output logic [mempool_pkg::num_tiles-1:0] gnt_o,
  input  logic                             advance_i
);

  import mempool_pkg::*;

  tile_id_t ptr_q;
  tile_id_t gnt_idx;
  logic     gnt_any;

  // First requester at or after the pointer, wrapping around
  always_comb begin
    tile_id_t idx;
    gnt_o   = '0;
    gnt_idx = '0;
    gnt_any = 1'b0;
    for (int i = 0; i < num_tiles; i++) begin
      idx = ptr_q + tile_id_t'(i);
      if (!gnt_any && req_i[idx]) begin
        gnt_o[idx] = 1'b1;
        gnt_idx    = idx;
        gnt_any    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (advance_i && gnt_any) begin
      ptr_q <= gnt_idx + tile_id_t'(1);
    end
  end

  a_gnt_legal : assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(gnt_o) && ((gnt_o & ~req_i) == '0));

endmodule : rr_arbiter

//--- interco/local_interco.sv
// ----------------------------------------------------------
// Sub-group local interconnect
// Crossbar from master ports to tiles and back by initiator
// ----------------------------------------------------------

module local_interco (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  // Master side
  input  logic                  [mempool_pkg::num_tiles-1:0]    req_valid_i,
  output logic                  [mempool_pkg::num_tiles-1:0]    req_ready_o,
  input  mempool_pkg::tcdm_addr_t [mempool_pkg::num_tiles-1:0]  req_addr_i,
  input  mempool_pkg::tcdm_op_e [mempool_pkg::num_tiles-1:0]    req_op_i,
  input  mempool_pkg::data_t    [mempool_pkg::num_tiles-1:0]    req_wdata_i,
  input  mempool_pkg::strb_t    [mempool_pkg::num_tiles-1:0]    req_be_i,
  output logic                  [mempool_pkg::num_tiles-1:0]    resp_valid_o,
  input  logic                  [mempool_pkg::num_tiles-1:0]    resp_ready_i,
  output mempool_pkg::data_t    [mempool_pkg::num_tiles-1:0]    resp_rdata_o,
  output logic                  [mempool_pkg::num_tiles-1:0]    resp_write_o,
  // Tile side
  output logic                  [mempool_pkg::num_tiles-1:0]    tile_req_valid_o,
  input  logic                  [mempool_pkg::num_tiles-1:0]    tile_req_ready_i,
  output mempool_pkg::tile_id_t [mempool_pkg::num_tiles-1:0]    tile_req_ini_o,
  output mempool_pkg::tile_addr_t [mempool_pkg::num_tiles-1:0]  tile_req_addr_o,
  output mempool_pkg::tcdm_op_e [mempool_pkg::num_tiles-1:0]    tile_req_op_o,
  output mempool_pkg::data_t    [mempool_pkg::num_tiles-1:0]    tile_req_wdata_o,
  output mempool_pkg::strb_t    [mempool_pkg::num_tiles-1:0]    tile_req_be_o,
  input  logic                  [mempool_pkg::num_tiles-1:0]    tile_resp_valid_i,
  output logic                  [mempool_pkg::num_tiles-1:0]    tile_resp_ready_o,
  input  mempool_pkg::tile_id_t [mempool_pkg::num_tiles-1:0]    tile_resp_ini_i,
  input  mempool_pkg::data_t    [mempool_pkg::num_tiles-1:0]    tile_resp_rdata_i,
  input  logic                  [mempool_pkg::num_tiles-1:0]    tile_resp_write_i
);

  import mempool_pkg::*;

  tile_id_t [num_tiles-1:0]                tgt;
  tile_id_t [num_tiles-1:0]                win_idx;
  logic     [num_tiles-1:0][num_tiles-1:0] arb_req;
  logic     [num_tiles-1:0][num_tiles-1:0] gnt;
  // Indexed [master][tile]
  logic     [num_tiles-1:0][num_tiles-1:0] resp_hit;

  logic [num_tiles-1:0] outstanding_q;
  logic [num_tiles-1:0] req_acc;
  logic [num_tiles-1:0] resp_take;

  // ----------------------------------------------------------
  // Request path
  // ----------------------------------------------------------

  for (genvar m = 0; m < num_tiles; m++) begin : gen_master
    assign tgt[m] = addr_tile(req_addr_i[m]);
    // Idle masters see ready when their target tile can take work
    assign req_ready_o[m] = !outstanding_q[m] && tile_req_ready_i[tgt[m]] &&
                            (!req_valid_i[m] || gnt[tgt[m]][m]);
  end : gen_master

  // Busy masters drop out of arbitration
  always_comb begin
    for (int t = 0; t < num_tiles; t++) begin
      for (int m = 0; m < num_tiles; m++) begin
        arb_req[t][m] = req_valid_i[m] && !outstanding_q[m] && (tgt[m] == tile_id_t'(t));
      end
    end
  end

  always_comb begin
    for (int t = 0; t < num_tiles; t++) begin
      win_idx[t] = '0;
      for (int m = 0; m < num_tiles; m++) begin
        if (gnt[t][m]) begin
          win_idx[t] = tile_id_t'(m);
        end
      end
    end
  end

  for (genvar t = 0; t < num_tiles; t++) begin : gen_tile
    rr_arbiter i_arb (
      .clk_i    (clk_i                                      ),
      .rst_i    (rst_i                                      ),
      .req_i    (arb_req[t]                                 ),
      .gnt_o    (gnt[t]                                     ),
      .advance_i(tile_req_valid_o[t] && tile_req_ready_i[t] )
    );

    assign tile_req_valid_o[t] = |arb_req[t];
    assign tile_req_ini_o[t]   = win_idx[t];
    assign tile_req_addr_o[t]  = addr_in_tile(req_addr_i[win_idx[t]]);
    assign tile_req_op_o[t]    = req_op_i[win_idx[t]];
    assign tile_req_wdata_o[t] = req_wdata_i[win_idx[t]];
    assign tile_req_be_o[t]    = req_be_i[win_idx[t]];

    assign tile_resp_ready_o[t] = resp_ready_i[tile_resp_ini_i[t]];
  end : gen_tile

  // ----------------------------------------------------------
  // Response path
  // ----------------------------------------------------------

  always_comb begin
    for (int m = 0; m < num_tiles; m++) begin
      for (int t = 0; t < num_tiles; t++) begin
        resp_hit[m][t] = tile_resp_valid_i[t] && (tile_resp_ini_i[t] == tile_id_t'(m));
      end
    end
  end

  always_comb begin
    resp_valid_o = '0;
    resp_rdata_o = '0;
    resp_write_o = '0;
    for (int m = 0; m < num_tiles; m++) begin
      for (int t = 0; t < num_tiles; t++) begin
        if (resp_hit[m][t]) begin
          resp_valid_o[m] = 1'b1;
          resp_rdata_o[m] = tile_resp_rdata_i[t];
          resp_write_o[m] = tile_resp_write_i[t];
        end
      end
    end
  end

  // One request in flight per master
  assign req_acc   = req_valid_i & req_ready_o;
  assign resp_take = resp_valid_o & resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= (outstanding_q | req_acc) & ~resp_take;
    end
  end

  // A response only reaches a master that is waiting, from one tile
  for (genvar m = 0; m < num_tiles; m++) begin : gen_resp_chk
    a_resp_unique : assert property (@(posedge clk_i) disable iff (rst_i)
      resp_valid_o[m] |-> outstanding_q[m] && $onehot0(resp_hit[m]));
  end : gen_resp_chk

endmodule : local_interco

//--- verilog/mempool_sub_group.sv
// ----------------------------------------------------------
// MemPool sub-group top level
// Local interconnect joined to four TCDM tiles
// ----------------------------------------------------------

module mempool_sub_group (
  input  logic                                                  clk_i,
  input  logic                                                  rst_i,
  input  logic                  [mempool_pkg::num_tiles-1:0]    req_valid_i,
  output logic                  [mempool_pkg::num_tiles-1:0]    req_ready_o,
  input  mempool_pkg::tcdm_addr_t [mempool_pkg::num_tiles-1:0]  req_addr_i,
  input  mempool_pkg::tcdm_op_e [mempool_pkg::num_tiles-1:0]    req_op_i,
  input  mempool_pkg::data_t    [mempool_pkg::num_tiles-1:0]    req_wdata_i,
  input  mempool_pkg::strb_t    [mempool_pkg::num_tiles-1:0]    req_be_i,
  output logic                  [mempool_pkg::num_tiles-1:0]    resp_valid_o,
  input  logic                  [mempool_pkg::num_tiles-1:0]    resp_ready_i,
  output mempool_pkg::data_t    [mempool_pkg::num_tiles-1:0]    resp_rdata_o,
  output logic                  [mempool_pkg::num_tiles-1:0]    resp_write_o
);

  import mempool_pkg::*;

  logic       [num_tiles-1:0] tile_req_valid;
  logic       [num_tiles-1:0] tile_req_ready;
  tile_id_t   [num_tiles-1:0] tile_req_ini;
  tile_addr_t [num_tiles-1:0] tile_req_addr;
  tcdm_op_e   [num_tiles-1:0] tile_req_op;
  data_t      [num_tiles-1:0] tile_req_wdata;
  strb_t      [num_tiles-1:0] tile_req_be;
  logic       [num_tiles-1:0] tile_resp_valid;
  logic       [num_tiles-1:0] tile_resp_ready;
  tile_id_t   [num_tiles-1:0] tile_resp_ini;
  data_t      [num_tiles-1:0] tile_resp_rdata;
  logic       [num_tiles-1:0] tile_resp_write;

  local_interco i_local_interco (
    .clk_i            (clk_i          ),
    .rst_i            (rst_i          ),
    .req_valid_i      (req_valid_i    ),
    .req_ready_o      (req_ready_o    ),
    .req_addr_i       (req_addr_i     ),
    .req_op_i         (req_op_i       ),
    .req_wdata_i      (req_wdata_i    ),
    .req_be_i         (req_be_i       ),
    .resp_valid_o     (resp_valid_o   ),
    .resp_ready_i     (resp_ready_i   ),
    .resp_rdata_o     (resp_rdata_o   ),
    .resp_write_o     (resp_write_o   ),
    .tile_req_valid_o (tile_req_valid ),
    .tile_req_ready_i (tile_req_ready ),
    .tile_req_ini_o   (tile_req_ini   ),
    .tile_req_addr_o  (tile_req_addr  ),
    .tile_req_op_o    (tile_req_op    ),
    .tile_req_wdata_o (tile_req_wdata ),
    .tile_req_be_o    (tile_req_be    ),
    .tile_resp_valid_i(tile_resp_valid),
    .tile_resp_ready_o(tile_resp_ready),
    .tile_resp_ini_i  (tile_resp_ini  ),
    .tile_resp_rdata_i(tile_resp_rdata),
    .tile_resp_write_i(tile_resp_write)
  );

  // ----------------------------------------------------------
  // Tiles
  // ----------------------------------------------------------

  for (genvar t = 0; t < num_tiles; t++) begin : gen_tiles
    mempool_tile i_tile (
      .clk_i       (clk_i             ),
      .rst_i       (rst_i             ),
      .req_valid_i (tile_req_valid[t] ),
      .req_ready_o (tile_req_ready[t] ),
      .req_ini_i   (tile_req_ini[t]   ),
      .req_addr_i  (tile_req_addr[t]  ),
      .req_op_i    (tile_req_op[t]    ),
      .req_wdata_i (tile_req_wdata[t] ),
      .req_be_i    (tile_req_be[t]    ),
      .resp_valid_o(tile_resp_valid[t]),
      .resp_ready_i(tile_resp_ready[t]),
      .resp_ini_o  (tile_resp_ini[t]  ),
      .resp_rdata_o(tile_resp_rdata[t]),
      .resp_write_o(tile_resp_write[t])
    );
  end : gen_tiles

endmodule : mempool_sub_group

//--- dv/tb_mempool_sub_group.sv
// ----------------------------------------------------------
// MemPool sub-group testbench
// Random and directed TCDM traffic checked against a model
// ----------------------------------------------------------

module tb_mempool_sub_group;

  import mempool_pkg::*;

  localparam int num_words = num_tiles * num_banks_per_tile * bank_depth;
  localparam int max_wait  = 200;

  logic                            clk = 1'b0;
  logic                            rst;
  logic       [num_tiles-1:0]      req_valid;
  logic       [num_tiles-1:0]      req_ready;
  tcdm_addr_t [num_tiles-1:0]      req_addr;
  tcdm_op_e   [num_tiles-1:0]      req_op;
  data_t      [num_tiles-1:0]      req_wdata;
  strb_t      [num_tiles-1:0]      req_be;
  logic       [num_tiles-1:0]      resp_valid;
  logic       [num_tiles-1:0]      resp_ready;
  data_t      [num_tiles-1:0]      resp_rdata;
  logic       [num_tiles-1:0]      resp_write;

  // Reference state
  data_t       ref_mem [num_words];
  tcdm_op_e    exp_op_q [num_tiles][$];
  data_t       exp_data_q [num_tiles][$];
  int          acc_cyc [num_tiles];
  int          done_cnt [num_tiles];
  logic        resp_seen [num_tiles];
  logic        held [num_tiles];
  data_t       held_data [num_tiles];
  int          cyc;
  logic [31:0] rng_state = 32'd11;

  mempool_sub_group DUT (
    .clk_i       (clk       ),
    .rst_i       (rst       ),
    .req_valid_i (req_valid ),
    .req_ready_o (req_ready ),
    .req_addr_i  (req_addr  ),
    .req_op_i    (req_op    ),
    .req_wdata_i (req_wdata ),
    .req_be_i    (req_be    ),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready),
    .resp_rdata_o(resp_rdata),
    .resp_write_o(resp_write)
  );

  always #10 clk = ~clk;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Byte-enable merge of a write into the old word
  function automatic data_t merge_write(data_t old_word, data_t wdata, strb_t be);
    data_t res;
    res = old_word;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // Layout is {row, tile, bank}
  function automatic tcdm_addr_t make_addr(int row, int tile, int bank);
    return {row_t'(row), tile_id_t'(tile), bank_id_t'(bank)};
  endfunction

  function automatic data_t fill_word(tcdm_addr_t addr);
    return {7'h55, addr, 7'h2a, addr};
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int m = 0; m < num_tiles; m++) begin
      n += exp_op_q[m].size();
    end
    return n;
  endfunction

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_op(string name, tcdm_op_e exp, tcdm_op_e act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      abort_run($sformatf("ERR %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_req(int m, tcdm_addr_t addr, tcdm_op_e op, data_t wdata, strb_t be);
    int waited;
    waited = 0;
    req_valid[m] = 1'b1;
    req_addr[m]  = addr;
    req_op[m]    = op;
    req_wdata[m] = wdata;
    req_be[m]    = be;
    @(negedge clk);
    while (!req_ready[m]) begin
      waited++;
      if (waited > max_wait) begin
        abort_run($sformatf("master %0d request was never accepted", m));
      end
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    req_valid[m] = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    while (pending_count() != 0) begin
      waited++;
      if (waited > max_wait) begin
        abort_run("responses still outstanding after the timeout");
      end
      @(posedge clk);
      #1;
    end
  endtask

  task automatic run_random(int m, int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      send_req(m, tcdm_addr_t'(r), tcdm_op_e'(r[9]), next_rand(), strb_t'(r[13:10]));
    end
  endtask

  task automatic run_own_tile(int m);
    send_req(m, make_addr(m + 8, m, 1), op_write, fill_word(tcdm_addr_t'(m)), '1);
    send_req(m, make_addr(m + 8, m, 1), op_read, '0, '0);
    send_req(m, make_addr(m + 9, m, 0), op_read, '0, '0);
  endtask

  // Master 0 stalls its response while the others use their own tiles
  task automatic stall_master0(int base[num_tiles]);
    send_req(0, make_addr(5, 0, 0), op_read, '0, '0);
    repeat (10) @(posedge clk);
    #1;
    for (int m = 1; m < num_tiles; m++) begin
      if (done_cnt[m] < base[m] + 3) begin
        abort_run($sformatf("master %0d made no progress during the stall", m));
      end
    end
    resp_ready[0] = 1'b1;
  endtask

  // ----------------------------------------------------------
  // Compare process
  // ----------------------------------------------------------

  always @(negedge clk) begin : compare_proc
    tcdm_addr_t addr;
    if (!rst) begin
      cyc++;
      for (int m = 0; m < num_tiles; m++) begin
        if (exp_op_q[m].size() > 0) begin
          check_flag($sformatf("req_ready_o[%0d]", m), 1'b0, req_ready[m]);
        end
        if (held[m]) begin
          check_flag($sformatf("resp_valid_o[%0d]", m), 1'b1, resp_valid[m]);
          check_data($sformatf("resp_rdata_o[%0d]", m), held_data[m], resp_rdata[m]);
        end
        if (resp_valid[m]) begin
          if (exp_op_q[m].size() == 0) begin
            abort_run($sformatf("master %0d got a response it never asked for", m));
          end
          if (!resp_seen[m] && cyc != acc_cyc[m] + 1) begin
            abort_run($sformatf("master %0d response was not one cycle after acceptance", m));
          end
          resp_seen[m] = 1'b1;
          if (resp_ready[m]) begin
            check_op($sformatf("resp_write_o[%0d]", m), exp_op_q[m][0],
                     tcdm_op_e'(resp_write[m]));
            if (exp_op_q[m][0] == op_read) begin
              check_data($sformatf("resp_rdata_o[%0d]", m), exp_data_q[m][0], resp_rdata[m]);
            end
            void'(exp_op_q[m].pop_front());
            void'(exp_data_q[m].pop_front());
            resp_seen[m] = 1'b0;
            done_cnt[m]++;
          end
        end
        held[m]      = resp_valid[m] && !resp_ready[m];
        held_data[m] = resp_rdata[m];
        if (req_valid[m] && req_ready[m]) begin
          addr = req_addr[m];
          if (req_op[m] == op_write) begin
            ref_mem[addr] = merge_write(ref_mem[addr], req_wdata[m], req_be[m]);
          end
          exp_op_q[m].push_back(req_op[m]);
          exp_data_q[m].push_back(ref_mem[addr]);
          acc_cyc[m] = cyc;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin : stimulus
    logic [31:0] r;
    int          base [num_tiles];
    rst        = 1'b1;
    req_valid  = '0;
    req_addr   = '0;
    req_wdata  = '0;
    req_be     = '0;
    resp_ready = '1;
    cyc        = 0;
    for (int m = 0; m < num_tiles; m++) begin
      req_op[m]    = op_read;
      acc_cyc[m]   = 0;
      done_cnt[m]  = 0;
      resp_seen[m] = 1'b0;
      held[m]      = 1'b0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    @(negedge clk);
    for (int m = 0; m < num_tiles; m++) begin
      check_flag($sformatf("resp_valid_o[%0d]", m), 1'b0, resp_valid[m]);
      check_flag($sformatf("req_ready_o[%0d]", m), 1'b1, req_ready[m]);
    end
    @(posedge clk);
    #1;

    // Full sweep from master 0 with some partial rewrites
    for (int a = 0; a < num_words; a++) begin
      send_req(0, tcdm_addr_t'(a), op_write, fill_word(tcdm_addr_t'(a)), '1);
    end
    for (int a = 0; a < num_words; a += 4) begin
      r = next_rand();
      send_req(0, tcdm_addr_t'(a), op_write, ~fill_word(tcdm_addr_t'(a)), strb_t'(r));
    end
    for (int a = 0; a < num_words; a++) begin
      send_req(0, tcdm_addr_t'(a), op_read, '0, '0);
    end
    wait_idle();

    fork
      run_random(0, 80);
      run_random(1, 80);
      run_random(2, 80);
      run_random(3, 80);
    join
    wait_idle();

    base          = done_cnt;
    resp_ready[0] = 1'b0;
    fork
      stall_master0(base);
      run_own_tile(1);
      run_own_tile(2);
      run_own_tile(3);
    join
    wait_idle();

    $display("TEST PASS");
    $finish;
  end

endmodule : tb_mempool_sub_group

//--- compile.f
common/mempool_pkg.sv
tile/tcdm_bank.sv
tile/mempool_tile.sv
interco/rr_arbiter.sv
interco/local_interco.sv
verilog/mempool_sub_group.sv
dv/tb_mempool_sub_group.sv

//--- Bender.yml
package:
  name: mempool_sub_group

sources:
  # Shared package
  - common/mempool_pkg.sv
  # Tile
  - tile/tcdm_bank.sv
  - tile/mempool_tile.sv
  # Local interconnect
  - interco/rr_arbiter.sv
  - interco/local_interco.sv
  # Top level
  - verilog/mempool_sub_group.sv
  # Testbench
  - target: test
    files:
      - dv/tb_mempool_sub_group.sv
